// File: hdl/armPkg.sv
package armPkg;

	localparam int WORD_W = 32;	// Data word width

	typedef enum logic [3:0]
	{
		OP_AND = 4'b0000,
		OP_EOR = 4'b0001,
		OP_SUB = 4'b0010,
		OP_RSB = 4'b0011,
		OP_ADD = 4'b0100,
		OP_ORR = 4'b1100,
		OP_MOV = 4'b1101,
		OP_BIC = 4'b1110,
		OP_MVN = 4'b1111
	} aluOpT;	// Bits 24:21

	typedef enum logic [2:0]
	{
		CLS_DP_REG = 3'b000,	// Data processing, shift by immediate
		CLS_DP_IMM = 3'b001,	// Data processing, rotated immediate
		CLS_BRANCH = 3'b101
	} instrClassT;	// Bits 27:25

	typedef enum logic [1:0] {SH_LSL, SH_LSR, SH_ASR, SH_ROR} shiftT;	// Bits 6:5

	typedef enum logic [1:0] {IDLE, DECODE, EXECUTE, DONE} ctrlStateT;

	typedef struct packed
	{
		logic n;
		logic z;
		logic c;
		logic v;
	} flagsT;

	// Adder ops take C and V from the adder, the rest keep V
	function automatic logic isArithOp(aluOpT op);
		return op inside {OP_SUB, OP_RSB, OP_ADD};
	endfunction

endpackage

// File: hdl/operandIf.sv
`timescale 1ns/100ps

interface operandIf
	import armPkg::*;
();

	logic [WORD_W-1:0] instr;	// Latched instruction word
	logic carryFlag;	// Current C flag
	logic [WORD_W-1:0] rnValue;
	logic [WORD_W-1:0] rmValue;

	modport control (output instr, output carryFlag);

	modport register (input instr, output rnValue, output rmValue);

	// Shifter and ALU both see the whole bundle
	modport operand (input instr, input carryFlag, input rnValue, input rmValue);

endinterface

// File: hdl/shifterOperand.sv
`timescale 1ns/100ps

module shifterOperand
	import armPkg::*;
(
	operandIf.operand ops,
	output logic [WORD_W-1:0] operand,
	output logic shiftCarry
);

	instrClassT instrClass;
	shiftT shiftType;
	logic [4:0] shiftAmt;
	logic [4:0] lslIndex;
	logic [4:0] carryIndex;
	logic [3:0] rotField;
	logic [WORD_W-1:0] immValue;
	logic [2*WORD_W-1:0] immRot;
	logic [2*WORD_W-1:0] rmRot;

	assign instrClass = instrClassT'(ops.instr[27:25]);
	assign shiftType = shiftT'(ops.instr[6:5]);
	assign shiftAmt = ops.instr[11:7];
	assign rotField = ops.instr[11:8];
	assign immValue = {24'd0, ops.instr[7:0]};

	assign lslIndex = 5'd0 - shiftAmt;	// 32 minus the amount, last bit out on the left
	assign carryIndex = shiftAmt - 5'd1;	// Last bit out on the right

	// Doubling the word turns a right shift into a rotate
	assign immRot = {immValue, immValue} >> {rotField, 1'b0};
	assign rmRot = {ops.rmValue, ops.rmValue} >> shiftAmt;

	always_comb
	begin
		operand = ops.rmValue;	// Pass Rm through by default
		shiftCarry = ops.carryFlag;
		case (instrClass)
			CLS_DP_IMM:
			begin
				operand = immRot[WORD_W-1:0];	// Immediate rotated right by 2*rot
				if (rotField != 4'd0)
					shiftCarry = immRot[WORD_W-1];
			end
			CLS_DP_REG:
			begin
				// Amount zero keeps Rm and the old carry
				if (!ops.instr[4] && shiftAmt != 5'd0)
				begin
					case (shiftType)
						SH_LSL:
						begin
							operand = ops.rmValue << shiftAmt;
							shiftCarry = ops.rmValue[lslIndex];
						end
						SH_LSR:
						begin
							operand = ops.rmValue >> shiftAmt;
							shiftCarry = ops.rmValue[carryIndex];
						end
						SH_ASR:
						begin
							operand = $signed(ops.rmValue) >>> shiftAmt;	// Sign fills from the left
							shiftCarry = ops.rmValue[carryIndex];
						end
						SH_ROR:
						begin
							operand = rmRot[WORD_W-1:0];
							shiftCarry = ops.rmValue[carryIndex];
						end
					endcase
				end
			end
			CLS_BRANCH:
			begin
				operand = {{6{ops.instr[23]}}, ops.instr[23:0], 2'b00};	// Word offset times four
			end
			default:
			begin
				operand = ops.rmValue;	// Unsupported class
			end
		endcase
	end

	// The latched word is unknown until the first instruction arrives
	always_comb
	begin
		assert ($isunknown(ops.instr) || instrClass inside {CLS_DP_REG, CLS_DP_IMM, CLS_BRANCH})
		else
			$error("Unsupported instruction class %b", ops.instr[27:25]);
	end

endmodule

// File: hdl/aluUnit.sv
`timescale 1ns/100ps

module aluUnit
	import armPkg::*;
(
	operandIf.operand ops,
	input logic [WORD_W-1:0] operand,
	input logic shiftCarry,
	output logic [WORD_W-1:0] result,
	output flagsT nextFlags
);

	aluOpT opcode;
	logic [WORD_W-1:0] addA;
	logic [WORD_W-1:0] addB;
	logic addCin;
	logic [WORD_W:0] sum;

	assign opcode = aluOpT'(ops.instr[24:21]);

	// Subtraction as A + ~B + 1
	always_comb
	begin
		addA = ops.rnValue;
		addB = operand;
		addCin = 1'b0;
		case (opcode)
			OP_SUB:
			begin
				addB = ~operand;
				addCin = 1'b1;
			end
			OP_RSB:
			begin
				addA = operand;
				addB = ~ops.rnValue;
				addCin = 1'b1;
			end
			default:
			begin
				addCin = 1'b0;
			end
		endcase
	end

	assign sum = {1'b0, addA} + {1'b0, addB} + {{WORD_W{1'b0}}, addCin};

	always_comb
	begin
		case (opcode)
			OP_AND: result = ops.rnValue & operand;
			OP_EOR: result = ops.rnValue ^ operand;
			OP_ORR: result = ops.rnValue | operand;
			OP_BIC: result = ops.rnValue & ~operand;
			OP_MOV: result = operand;
			OP_MVN: result = ~operand;
			default: result = sum[WORD_W-1:0];	// SUB, RSB, ADD
		endcase
	end

	always_comb
	begin
		nextFlags.n = result[WORD_W-1];
		nextFlags.z = (result == '0);
		if (isArithOp(opcode))
		begin
			nextFlags.c = sum[WORD_W];	// Carry out, not borrow
			nextFlags.v = (addA[WORD_W-1] == addB[WORD_W-1]) && (sum[WORD_W-1] != addA[WORD_W-1]);
		end
		else
		begin
			nextFlags.c = shiftCarry;
			nextFlags.v = 1'b0;	// Flag register keeps V for logical ops
		end
	end

endmodule

// File: hdl/registerFile.sv
`timescale 1ns/100ps

module registerFile
	import armPkg::*;
#(
	parameter int REG_ADDR_W = 4
)
(
	input logic clk,
	input logic rstN,
	input logic wbEn,
	input logic [WORD_W-1:0] wbData,
	input logic regWrite,
	input logic [REG_ADDR_W-1:0] regWriteAddr,
	input logic [WORD_W-1:0] regWriteData,
	input logic [REG_ADDR_W-1:0] regReadAddr,
	output logic [WORD_W-1:0] regReadData,
	operandIf.register ops
);

	localparam int DEPTH = 1 << REG_ADDR_W;

	logic [WORD_W-1:0] regs [DEPTH];
	logic [REG_ADDR_W-1:0] rdAddr;

	assign rdAddr = ops.instr[12 +: REG_ADDR_W];	// Rd field

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < DEPTH; i++)
				regs[i] <= '0;
		end
		else
		begin
			if (regWrite)
				regs[regWriteAddr] <= regWriteData;	// Preload port
			if (wbEn)
				regs[rdAddr] <= wbData;	// Later assignment, core wins a clash
		end
	end

	assign ops.rnValue = regs[ops.instr[16 +: REG_ADDR_W]];
	assign ops.rmValue = regs[ops.instr[0 +: REG_ADDR_W]];
	assign regReadData = regs[regReadAddr];	// Observation port

endmodule

// File: hdl/programCounter.sv
`timescale 1ns/100ps

module programCounter
	import armPkg::*;
(
	input logic clk,
	input logic rstN,
	input logic pcStep,
	input logic pcBranch,
	input logic [WORD_W-1:0] offset,
	output logic [WORD_W-1:0] pc
);

	logic [WORD_W-1:0] pcInc;

	assign pcInc = pcBranch ? offset : WORD_W'(4);	// Offset is already in bytes

	always_ff @(posedge clk)
	begin
		if (!rstN)
			pc <= '0;
		else if (pcStep)
			pc <= pc + pcInc;
	end

endmodule

// File: hdl/executeControl.sv
`timescale 1ns/100ps

module executeControl
	import armPkg::*;
#(
	parameter int REG_ADDR_W = 4
)
(
	input logic clk,
	input logic rstN,
	input logic instrValid,
	input logic [WORD_W-1:0] instrWord,
	input logic [WORD_W-1:0] result,
	input flagsT nextFlags,
	operandIf.control ops,
	output logic wbEn,
	output logic pcStep,
	output logic pcBranch,
	output logic busy,
	output logic done,
	output flagsT flags
);

	ctrlStateT stateQ;
	logic [WORD_W-1:0] instrQ;
	flagsT flagsQ;
	logic isBranch;
	logic setFlags;

	assign isBranch = (instrClassT'(instrQ[27:25]) == CLS_BRANCH);
	assign setFlags = instrQ[20] && !isBranch;	// Bit 20 is offset in a branch

	always_ff @(posedge clk)
	begin
		if (!rstN)
			stateQ <= IDLE;
		else
		begin
			case (stateQ)
				IDLE: if (instrValid) stateQ <= DECODE;
				DECODE: stateQ <= EXECUTE;
				EXECUTE: stateQ <= DONE;
				default: stateQ <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (stateQ == IDLE && instrValid)
			instrQ <= instrWord;	// New word only when idle
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
			flagsQ <= '0;
		else if (stateQ == EXECUTE && setFlags)
		begin
			if (isArithOp(aluOpT'(instrQ[24:21])))
				flagsQ <= nextFlags;
			else
				flagsQ <= {nextFlags.n, nextFlags.z, nextFlags.c, flagsQ.v};
		end
	end

	assign wbEn = (stateQ == EXECUTE) && !isBranch;
	assign pcStep = (stateQ == EXECUTE);
	assign pcBranch = isBranch;
	assign busy = (stateQ != IDLE);
	assign done = (stateQ == DONE);
	assign flags = flagsQ;
	assign ops.instr = instrQ;
	assign ops.carryFlag = flagsQ.c;

	assert property (@(posedge clk) disable iff (!rstN) done |=> !done)
	else
		$error("done high for more than one cycle");

	// An unknown word or register value must not reach Rd
	assert property (@(posedge clk) disable iff (!rstN)
		wbEn |-> !$isunknown(result))
	else
		$error("Unknown ALU result written back");

	assert property (@(posedge clk) disable iff (!rstN)
		wbEn |-> (int'(instrQ[15:12]) < (1 << REG_ADDR_W)))
	else
		$error("Rd %0d outside register file", instrQ[15:12]);

endmodule

// File: hdl/armExecCore.sv
`timescale 1ns/100ps

module armExecCore
	import armPkg::*;
#(
	parameter int REG_ADDR_W = 4
)
(
	input logic clk,
	input logic rstN,
	input logic instrValid,
	input logic [WORD_W-1:0] instrWord,
	input logic regWrite,
	input logic [REG_ADDR_W-1:0] regWriteAddr,
	input logic [WORD_W-1:0] regWriteData,
	input logic [REG_ADDR_W-1:0] regReadAddr,
	output logic [WORD_W-1:0] regReadData,
	output logic busy,
	output logic done,
	output flagsT flags,
	output logic [WORD_W-1:0] pc
);

	logic [WORD_W-1:0] operand;	// Shifter output, also the branch offset
	logic shiftCarry;
	logic [WORD_W-1:0] aluResult;
	flagsT nextFlags;
	logic wbEn;
	logic pcStep;
	logic pcBranch;

	operandIf ops ();

	executeControl #(.REG_ADDR_W(REG_ADDR_W)) i_executeControl
	(
		.clk(clk), .rstN(rstN), .instrValid(instrValid), .instrWord(instrWord),
		.result(aluResult), .nextFlags(nextFlags), .ops(ops.control),
		.wbEn(wbEn), .pcStep(pcStep), .pcBranch(pcBranch),
		.busy(busy), .done(done), .flags(flags)
	);

	registerFile #(.REG_ADDR_W(REG_ADDR_W)) i_registerFile
	(
		.clk(clk), .rstN(rstN), .wbEn(wbEn), .wbData(aluResult),
		.regWrite(regWrite), .regWriteAddr(regWriteAddr), .regWriteData(regWriteData),
		.regReadAddr(regReadAddr), .regReadData(regReadData), .ops(ops.register)
	);

	shifterOperand i_shifterOperand (.ops(ops.operand), .operand(operand), .shiftCarry(shiftCarry));

	aluUnit i_aluUnit
	(
		.ops(ops.operand), .operand(operand), .shiftCarry(shiftCarry),
		.result(aluResult), .nextFlags(nextFlags)
	);

	programCounter i_programCounter
	(
		.clk(clk), .rstN(rstN), .pcStep(pcStep), .pcBranch(pcBranch),
		.offset(operand), .pc(pc)
	);

endmodule

// File: testbench/tbVectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Columns: instruction word, poke (a second instrValid pulse while busy)
// Expected Rd, flags and PC are filled in from the reference model before the run
typedef struct packed
{
	logic [31:0] word;
	logic poke;
} stimT;

typedef struct
{
	logic [31:0] word;
	logic poke;
	logic [31:0] rd;	// Expected Rd value after the instruction
	logic [3:0] flags;	// Expected n, z, c, v
	logic [31:0] pc;	// Expected PC
} vecT;

localparam int NUM_VECS = 19;
localparam logic [31:0] POKE_WORD = 32'hE3B09000;	// MOVS r9, #0

localparam stimT STIM [NUM_VECS] = '{
	{32'hE3A050FF, 1'b0},	// MOV r5, #0xFF
	{32'hE3B064FF, 1'b0},	// MOVS r6, #0xFF ror 8, C from bit 31
	{32'hE3B0AF3F, 1'b0},	// MOVS r10, #0x3F ror 30, C cleared
	{32'hE2917001, 1'b0},	// ADDS r7, r1, #1 overflows
	{32'hE2908F3F, 1'b0},	// ADDS r8, r0, #0xFC
	{32'hE1B0A083, 1'b0},	// MOVS r10, r3, LSL #1
	{32'hE1B0B0A2, 1'b0},	// MOVS r11, r2, LSR #1
	{32'hE1B0C243, 1'b0},	// MOVS r12, r3, ASR #4
	{32'hE1B0D0E2, 1'b0},	// MOVS r13, r2, ROR #1
	{32'hE1B0E000, 1'b0},	// MOVS r14, r0, LSL #0 keeps C
	{32'hE03E56E6, 1'b0},	// EORS r5, r14, r6, ROR #13
	{32'hE1D04F8F, 1'b0},	// BICS r4, r0, r15, LSL #31
	{32'hE0538002, 1'b0},	// SUBS r8, r3, r2 overflows
	{32'hE0529002, 1'b0},	// SUBS r9, r2, r2 gives zero
	{32'hE272A000, 1'b0},	// RSBS r10, r2, #0
	{32'hE073B001, 1'b0},	// RSBS r11, r3, r1 overflows
	{32'hEA000008, 1'b0},	// B +8 words
	{32'hEAFFFFFA, 1'b0},	// B -6 words
	{32'hE0809006, 1'b1}	// ADD r9, r0, r6 with a pulse while busy
};

`endif

// File: testbench/tb_armExecCore.sv
`timescale 1ns/100ps

module tb_armExecCore
	import armPkg::*;
;

	localparam int REG_ADDR_W = 4;
	localparam int DONE_TIMEOUT = 20;	// Edges to wait for done

	`include "tbVectors.svh"

	logic clk;
	logic rstN;
	logic instrValid;
	logic [31:0] instrWord;
	logic regWrite;
	logic [REG_ADDR_W-1:0] regWriteAddr;
	logic [31:0] regWriteData;
	logic [REG_ADDR_W-1:0] regReadAddr;
	logic [31:0] regReadData;
	logic busy;
	logic done;
	flagsT flags;
	logic [31:0] pc;

	int errorCount;
	int timeoutCount;
	int seed;
	logic [31:0] modelRegs [16];	// Reference register file
	logic [3:0] modelFlags;	// n, z, c, v
	logic [31:0] modelPc;
	vecT vecs [NUM_VECS];

	armExecCore #(.REG_ADDR_W(REG_ADDR_W)) i_armExecCore
	(
		.clk(clk), .rstN(rstN), .instrValid(instrValid), .instrWord(instrWord),
		.regWrite(regWrite), .regWriteAddr(regWriteAddr), .regWriteData(regWriteData),
		.regReadAddr(regReadAddr), .regReadData(regReadData),
		.busy(busy), .done(done), .flags(flags), .pc(pc)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic checkValue(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("Fail at %0t ns: %s got %h, expected %h", $time, what, got, exp);
			errorCount++;
		end
	endtask

	// Returns {carry, operand}, one bit position per loop step
	function automatic logic [32:0] shiftModel(logic [31:0] word, logic [31:0] rm, logic cIn);
		logic [31:0] val;
		logic c;
		int steps;
		int i;
		val = rm;
		c = cIn;
		if (word[27:25] == 3'b001)
		begin
			val = {24'd0, word[7:0]};
			steps = 2 * int'(word[11:8]);
			for (i = 0; i < steps; i++)
				val = {val[0], val[31:1]};
			if (steps != 0)
				c = val[31];
		end
		else if (word[27:25] == 3'b101)
			val = {{8{word[23]}}, word[23:0]} * 32'd4;	// Signed word count in bytes
		else
		begin
			steps = int'(word[11:7]);
			for (i = 0; i < steps; i++)
			begin
				case (word[6:5])
					2'b00:
					begin
						c = val[31];
						val = val << 1;
					end
					2'b01:
					begin
						c = val[0];
						val = val >> 1;
					end
					2'b10:
					begin
						c = val[0];
						val = {val[31], val[31:1]};
					end
					default:
					begin
						c = val[0];
						val = {val[0], val[31:1]};
					end
				endcase
			end
		end
		return {c, val};
	endfunction

	task automatic modelExec(input logic [31:0] word);
		logic [32:0] sh;
		logic [31:0] rn;
		logic [31:0] res;
		logic c;
		logic v;
		rn = modelRegs[word[19:16]];
		sh = shiftModel(word, modelRegs[word[3:0]], modelFlags[1]);
		c = sh[32];	// Logical ops take the shifter carry
		v = modelFlags[0];
		case (word[24:21])
			4'b0000: res = rn & sh[31:0];
			4'b0001: res = rn ^ sh[31:0];
			4'b1100: res = rn | sh[31:0];
			4'b1110: res = rn & ~sh[31:0];
			4'b1111: res = ~sh[31:0];
			4'b0010:
			begin
				res = rn - sh[31:0];
				c = (rn >= sh[31:0]);	// No borrow
				v = (rn[31] != sh[31]) && (res[31] != rn[31]);
			end
			4'b0011:
			begin
				res = sh[31:0] - rn;
				c = (sh[31:0] >= rn);
				v = (sh[31] != rn[31]) && (res[31] != sh[31]);
			end
			4'b0100:
			begin
				{c, res} = {1'b0, rn} + {1'b0, sh[31:0]};
				v = (rn[31] == sh[31]) && (res[31] != rn[31]);
			end
			default: res = sh[31:0];	// MOV
		endcase
		if (word[27:25] == 3'b101)
			modelPc = modelPc + sh[31:0];
		else
		begin
			modelRegs[word[15:12]] = res;
			if (word[20])
				modelFlags = {res[31], res == 32'd0, c, v};
			modelPc = modelPc + 32'd4;
		end
	endtask

	// Pulses instrValid, counts edges from the sampling edge until done is seen
	task automatic issue(input logic [31:0] word, input logic poke, output int edges);
		int count;
		@(posedge clk);
		instrValid <= 1'b1;
		instrWord <= word;
		regReadAddr <= word[15:12];
		@(posedge clk);	// DUT samples instrValid here
		count = 1;
		instrValid <= poke;
		instrWord <= poke ? POKE_WORD : word;
		@(negedge clk);
		while (!done && count < DONE_TIMEOUT)
		begin
			@(posedge clk);
			count++;
			instrValid <= 1'b0;
			@(negedge clk);
		end
		edges = done ? count : -1;
	endtask

	initial
	begin
		logic [31:0] data;
		int edges;
		int v;
		int i;
		seed = 32'ha47b1b23;
		rstN = 1'b0;
		instrValid = 1'b0;
		instrWord = '0;
		regWrite = 1'b0;
		regWriteAddr = '0;
		regWriteData = '0;
		regReadAddr = '0;
		errorCount = 0;
		timeoutCount = 0;
		repeat (2) @(posedge clk);
		rstN <= 1'b1;

		for (i = 0; i < 16; i++)
		begin
			data = $random(seed);
			case (i)
				1: data = 32'h7FFFFFFF;	// Edge values for the overflow rows
				2: data = 32'h00000001;
				3: data = 32'h80000000;
				default: ;
			endcase
			@(posedge clk);
			regWrite <= 1'b1;
			regWriteAddr <= REG_ADDR_W'(i);
			regWriteData <= data;
			modelRegs[i] = data;
		end
		@(posedge clk);
		regWrite <= 1'b0;

		modelFlags = '0;
		modelPc = '0;
		for (v = 0; v < NUM_VECS; v++)
		begin
			vecs[v].word = STIM[v].word;
			vecs[v].poke = STIM[v].poke;
			modelExec(STIM[v].word);
			vecs[v].rd = modelRegs[STIM[v].word[15:12]];
			vecs[v].flags = modelFlags;
			vecs[v].pc = modelPc;
		end

		for (v = 0; v < NUM_VECS && timeoutCount == 0; v++)
		begin
			issue(vecs[v].word, vecs[v].poke, edges);
			if (edges < 0)
			begin
				$display("Timeout: done never came for vector %0d", v);
				timeoutCount++;
			end
			else
			begin
				checkValue("edges to done", 32'(edges), 32'd3);
				checkValue("busy at done", 32'(busy), 32'd1);
				checkValue("Rd", regReadData, vecs[v].rd);
				checkValue("flags", {28'd0, flags}, {28'd0, vecs[v].flags});
				checkValue("pc", pc, vecs[v].pc);
				@(posedge clk);
				@(negedge clk);
				checkValue("busy after done", 32'(busy), 32'd0);
				checkValue("done after one cycle", 32'(done), 32'd0);
			end
		end

		// Whole register file against the model, catches stray writes
		for (i = 0; i < 16 && timeoutCount == 0; i++)
		begin
			@(posedge clk);
			regReadAddr <= REG_ADDR_W'(i);
			@(negedge clk);
			checkValue($sformatf("r%0d", i), regReadData, modelRegs[i]);
		end

		$display("Summary: %0d mismatches, %0d timeouts", errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// File: tb.f
+incdir+testbench
hdl/armPkg.sv
hdl/operandIf.sv
hdl/shifterOperand.sv
hdl/aluUnit.sv
hdl/registerFile.sv
hdl/programCounter.sv
hdl/executeControl.sv
hdl/armExecCore.sv
testbench/tb_armExecCore.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the armExecCore testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -sv -f tb.f --top-module tb_armExecCore \
	-Mdir obj_dir -o simTb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "\*\*\* TEST FAILED \*\*\*" "$LOG"; then
	exit 1
fi
exit 0
